// File: fft_config.svh
`ifndef FFT_CONFIG_SVH
`define FFT_CONFIG_SVH

// frame geometry.
`define FFT_POINTS 16
`define FFT_STAGES 4

// fixed-point format, twiddles share the sample width.
`define FFT_SAMPLE_W 24
`define FFT_FRAC_W 23

`endif

// File: fft_pkg.sv
`default_nettype none

`include "fft_config.svh"

package fft_pkg;

	////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////
	typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;
	typedef logic [`FFT_SAMPLE_W-1:0] mag_t;

	typedef sample_t [`FFT_POINTS-1:0] frame_t; // indexed by sample or bin.
	typedef mag_t [`FFT_POINTS-1:0] mag_frame_t;

	typedef logic [$clog2(`FFT_STAGES)-1:0] stage_idx_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_compute,
		seq_emit
	} seq_state_t;

	////////////////////////////////////////////////////////////
	// twiddles W16^k, k = 0..7, Q1.23
	////////////////////////////////////////////////////////////
	localparam sample_t TWIDDLE_RE [`FFT_POINTS/2] = '{
		24'h7FFFFF, 24'h7641B3, 24'h5A827A, 24'h30FBC2,
		24'h000000, 24'hCF043E, 24'hA57D86, 24'h89BE4D
	};

	localparam sample_t TWIDDLE_IM [`FFT_POINTS/2] = '{
		24'h000000, 24'hCF043E, 24'hA57D86, 24'h89BE4D,
		24'h800000, 24'h89BE4D, 24'hA57D86, 24'hCF043E
	};

endpackage

`default_nettype wire

// File: fft_butterfly.sv
`default_nettype none

`include "fft_config.svh"

module fft_butterfly
	import fft_pkg::*;
(
	input  sample_t a_re,
	input  sample_t a_im,
	input  sample_t b_re,
	input  sample_t b_im,
	input  sample_t w_re,
	input  sample_t w_im,
	output sample_t sum_re,
	output sample_t sum_im,
	output sample_t diff_re,
	output sample_t diff_im
);

	// one guard bit over the product width.
	logic signed [2*`FFT_SAMPLE_W:0] prod_re;
	logic signed [2*`FFT_SAMPLE_W:0] prod_im;
	sample_t t_re;
	sample_t t_im;

	assign prod_re = b_re * w_re - b_im * w_im;
	assign prod_im = b_re * w_im + b_im * w_re;

	// rescale by the twiddle fraction, wrap to sample width.
	assign t_re = prod_re[`FFT_FRAC_W +: `FFT_SAMPLE_W];
	assign t_im = prod_im[`FFT_FRAC_W +: `FFT_SAMPLE_W];

	assign sum_re  = a_re + t_re;
	assign sum_im  = a_im + t_im;
	assign diff_re = a_re - t_re;
	assign diff_im = a_im - t_im;

endmodule

`default_nettype wire

// File: fft_stage.sv
`default_nettype none

`include "fft_config.svh"

module fft_stage
	import fft_pkg::*;
(
	input  stage_idx_t stage,
	input  frame_t     cur_re,
	input  frame_t     cur_im,
	output frame_t     nxt_re,
	output frame_t     nxt_im
);

	localparam int PAIRS = `FFT_POINTS / 2;

	logic [`FFT_STAGES-1:0] span;
	logic [`FFT_STAGES-1:0] mask;
	logic [`FFT_STAGES-1:0] top_idx [PAIRS];
	logic [`FFT_STAGES-1:0] bot_idx [PAIRS];
	logic [`FFT_STAGES-1:0] tw_idx [PAIRS];
	sample_t sum_re [PAIRS];
	sample_t sum_im [PAIRS];
	sample_t diff_re [PAIRS];
	sample_t diff_im [PAIRS];

	assign span = {{(`FFT_STAGES-1){1'b0}}, 1'b1} << stage;
	assign mask = span - 1'b1;

	for (genvar g = 0; g < PAIRS; g++)
	begin : g_pair
		localparam logic [`FFT_STAGES-1:0] PAIR = g;

		// open a zero at bit "stage" of the pair number.
		assign top_idx[g] = ((PAIR & ~mask) << 1) | (PAIR & mask);
		assign bot_idx[g] = top_idx[g] | span;
		assign tw_idx[g]  = (PAIR & mask) << (`FFT_STAGES - 1 - stage);

		fft_butterfly i_butterfly (
			.a_re    (cur_re[top_idx[g]]),
			.a_im    (cur_im[top_idx[g]]),
			.b_re    (cur_re[bot_idx[g]]),
			.b_im    (cur_im[bot_idx[g]]),
			.w_re    (TWIDDLE_RE[tw_idx[g][`FFT_STAGES-2:0]]),
			.w_im    (TWIDDLE_IM[tw_idx[g][`FFT_STAGES-2:0]]),
			.sum_re  (sum_re[g]),
			.sum_im  (sum_im[g]),
			.diff_re (diff_re[g]),
			.diff_im (diff_im[g])
		);
	end

	// results go back to the indices they were read from.
	always_comb
	begin
		nxt_re = cur_re;
		nxt_im = cur_im;
		for (int p = 0; p < PAIRS; p++)
		begin
			nxt_re[top_idx[p]] = sum_re[p];
			nxt_im[top_idx[p]] = sum_im[p];
			nxt_re[bot_idx[p]] = diff_re[p];
			nxt_im[bot_idx[p]] = diff_im[p];
		end
	end

endmodule

`default_nettype wire

// File: fft_sequencer.sv
`default_nettype none

`include "fft_config.svh"

module fft_sequencer
	import fft_pkg::*;
(
	input  logic       Clk,
	input  logic       Reset,
	input  logic       Ready,
	output logic       load,
	output logic       advance,
	output logic       emit,
	output stage_idx_t stage,
	output logic       frame_completed
);

	seq_state_t state;

	////////////////////////////////////////////////////////////
	// frame control
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= seq_idle;
			stage <= '0;
		end
		else
		begin
			case (state)
				seq_idle:
				begin
					if (Ready)
					begin
						state <= seq_compute;
						stage <= '0;
					end
				end
				seq_compute:
				begin
					if (stage == stage_idx_t'(`FFT_STAGES-1))
						state <= seq_emit; // last pass written back.
					stage <= stage + 1'b1;
				end
				seq_emit: state <= seq_idle;
				default:  state <= seq_idle;
			endcase
		end
	end

	// load must land on the same edge that sees Ready.
	assign load            = (state == seq_idle) && Ready;
	assign advance         = (state == seq_compute);
	assign emit            = (state == seq_emit);
	assign frame_completed = (state == seq_idle);

	// load edge, one edge per pass, then the emit edge.
	a_done_after_frame: assert property (@(posedge Clk) disable iff (Reset)
		$rose(frame_completed) |-> $past(load, `FFT_STAGES + 2));

	a_emit_after_last_pass: assert property (@(posedge Clk) disable iff (Reset)
		emit |-> $past(advance) && $past(stage) == stage_idx_t'(`FFT_STAGES-1));

endmodule

`default_nettype wire

// File: fft_frame_buffer.sv
`default_nettype none

`include "fft_config.svh"

module fft_frame_buffer
	import fft_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   load,
	input  logic   advance,
	input  frame_t samples,
	input  frame_t nxt_re,
	input  frame_t nxt_im,
	output frame_t cur_re,
	output frame_t cur_im
);

	// reverse the low address bits of a sample index.
	function automatic int bit_rev(input int idx);
		int rev = 0;
		for (int b = 0; b < `FFT_STAGES; b++)
		begin
			if (idx[b])
				rev |= 1 << (`FFT_STAGES - 1 - b);
		end
		return rev;
	endfunction

	////////////////////////////////////////////////////////////
	// working frame, written in place
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			cur_re <= '0;
			cur_im <= '0;
		end
		else if (load)
		begin
			for (int i = 0; i < `FFT_POINTS; i++)
				cur_re[i] <= samples[bit_rev(i)];
			cur_im <= '0; // real input frame.
		end
		else if (advance)
		begin
			cur_re <= nxt_re;
			cur_im <= nxt_im;
		end
	end

	a_load_vs_advance: assert property (@(posedge Clk) disable iff (Reset)
		!(load && advance));

endmodule

`default_nettype wire

// File: fft_magnitude_out.sv
`default_nettype none

`include "fft_config.svh"

module fft_magnitude_out
	import fft_pkg::*;
(
	input  logic       Clk,
	input  logic       Reset,
	input  logic       emit,
	input  frame_t     bins_re,
	output mag_frame_t x
);

	////////////////////////////////////////////////////////////
	// absolute value of each real bin
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			x <= '0;
		else if (emit)
		begin
			for (int i = 0; i < `FFT_POINTS; i++)
			begin
				// 800000 negates to itself, read unsigned.
				x[i] <= bins_re[i][`FFT_SAMPLE_W-1] ? mag_t'(-bins_re[i])
					: mag_t'(bins_re[i]);
			end
		end
	end

endmodule

`default_nettype wire

// File: fft_core.sv
`default_nettype none

module fft_core
	import fft_pkg::*;
(
	input  logic       Clk,
	input  logic       Reset,
	input  logic       Ready,
	input  frame_t     s,
	output mag_frame_t x,
	output logic       frame_completed
);

	logic       load;
	logic       advance;
	logic       emit;
	stage_idx_t stage;
	frame_t     cur_re;
	frame_t     cur_im;
	frame_t     nxt_re;
	frame_t     nxt_im;

	fft_sequencer i_sequencer (
		.Clk             (Clk),
		.Reset           (Reset),
		.Ready           (Ready),
		.load            (load),
		.advance         (advance),
		.emit            (emit),
		.stage           (stage),
		.frame_completed (frame_completed)
	);

	fft_frame_buffer i_frame_buffer (
		.Clk     (Clk),
		.Reset   (Reset),
		.load    (load),
		.advance (advance),
		.samples (s),
		.nxt_re  (nxt_re),
		.nxt_im  (nxt_im),
		.cur_re  (cur_re),
		.cur_im  (cur_im)
	);

	fft_stage i_stage (
		.stage  (stage),
		.cur_re (cur_re),
		.cur_im (cur_im),
		.nxt_re (nxt_re),
		.nxt_im (nxt_im)
	);

	fft_magnitude_out i_magnitude_out (
		.Clk     (Clk),
		.Reset   (Reset),
		.emit    (emit),
		.bins_re (cur_re),
		.x       (x)
	);

endmodule

`default_nettype wire

// File: tb_fft_core.sv
`default_nettype none

`include "fft_config.svh"

module tb_fft_core
	import fft_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES   = 8;
	localparam int FRAME_CYCLES = 6;
	localparam int CLK_NS       = 10;
	localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_CYCLES * CLK_NS * 4 + 200;
	localparam int BUSY_CYCLES  = 5;
	localparam int BUSY_LIMIT   = 20;

	logic       Clk;
	logic       Reset;
	logic       Ready;
	frame_t     s;
	mag_frame_t x;
	logic       frame_completed;

	frame_t     stim [NUM_FRAMES];
	mag_frame_t exp_mag [NUM_FRAMES];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;

	fft_core i_dut (
		.Clk             (Clk),
		.Reset           (Reset),
		.Ready           (Ready),
		.s               (s),
		.x               (x),
		.frame_completed (frame_completed)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(CLK_NS / 2) Clk = ~Clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic mag_frame_t fft_model(input frame_t smp);
		sample_t re [`FFT_POINTS];
		sample_t im [`FFT_POINTS];
		sample_t t_re;
		sample_t t_im;
		logic [`FFT_STAGES-1:0] n;
		int span;
		int k;
		longint p_re;
		longint p_im;
		mag_frame_t m;
		for (int i = 0; i < `FFT_POINTS; i++)
		begin
			n = i[`FFT_STAGES-1:0];
			re[i] = smp[{n[0], n[1], n[2], n[3]}]; // bit-reversed pick.
			im[i] = '0;
		end
		for (int st = 0; st < `FFT_STAGES; st++)
		begin
			span = 1 << st;
			for (int i = 0; i < `FFT_POINTS; i++)
			begin
				if ((i & span) == 0)
				begin
					k = (i % span) * ((`FFT_POINTS / 2) / span);
					p_re = longint'(re[i + span]) * longint'(TWIDDLE_RE[k])
						- longint'(im[i + span]) * longint'(TWIDDLE_IM[k]);
					p_im = longint'(re[i + span]) * longint'(TWIDDLE_IM[k])
						+ longint'(im[i + span]) * longint'(TWIDDLE_RE[k]);
					t_re = sample_t'(p_re >>> `FFT_FRAC_W);
					t_im = sample_t'(p_im >>> `FFT_FRAC_W);
					re[i + span] = re[i] - t_re;
					im[i + span] = im[i] - t_im;
					re[i] = re[i] + t_re;
					im[i] = im[i] + t_im;
				end
			end
		end
		for (int i = 0; i < `FFT_POINTS; i++)
			m[i] = re[i][`FFT_SAMPLE_W-1] ? mag_t'(~re[i]) + mag_t'(1) : mag_t'(re[i]);
		return m;
	endfunction

	// bounded to 2^18 so stages stay in range.
	function automatic frame_t random_frame();
		frame_t f;
		for (int n = 0; n < `FFT_POINTS; n++)
			f[n] = sample_t'(int'($urandom_range(524288, 0)) - 262144);
		return f;
	endfunction

	task automatic build_table();
		for (int n = 0; n < `FFT_POINTS; n++)
		begin
			stim[0][n] = (n == 0) ? sample_t'(24'h200000) : '0;
			stim[1][n] = sample_t'(24'h040000);
			stim[2][n] = (n % 2 == 0) ? sample_t'(24'h040000) : sample_t'(-262144);
			stim[3][n] = (n < 8) ? (TWIDDLE_RE[n] >>> 4) : -(TWIDDLE_RE[n - 8] >>> 4);
			stim[4][n] = sample_t'(-(65536 + n * 4096));
		end
		for (int f = 5; f < NUM_FRAMES; f++)
			stim[f] = random_frame();
		for (int f = 0; f < NUM_FRAMES; f++)
			exp_mag[f] = fft_model(stim[f]);
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	task automatic check_mag(input string name, input mag_t exp, input mag_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0d ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_frame(input mag_frame_t exp);
		for (int i = 0; i < `FFT_POINTS; i++)
			check_mag($sformatf("x[%0d]", i), exp[i], x[i]);
	endtask

	// starts one cycle after E0, returns one cycle after E5.
	task automatic wait_done(input mag_frame_t hold, input bit toggle);
		int cycles;
		cycles = 0;
		while (frame_completed !== 1'b1 && cycles < BUSY_LIMIT)
		begin
			check_frame(hold); // x must not move while busy.
			if (toggle)
			begin
				Ready = ~Ready;
				s = random_frame();
			end
			@(posedge Clk);
			#1;
			cycles++;
		end
		if (frame_completed !== 1'b1)
		begin
			errors++;
			$display("Error at %0d ns: frame_completed did not rise within %0d cycles",
				$time, BUSY_LIMIT);
		end
		else if (cycles != BUSY_CYCLES)
		begin
			errors++;
			$display("Error at %0d ns: busy time was %0d cycles instead of %0d",
				$time, cycles, BUSY_CYCLES);
		end
	endtask

	task automatic apply_frame(input int idx, input bit toggle, input mag_frame_t hold);
		s = stim[idx];
		Ready = 1'b1;
		check_bit("frame_completed", 1'b1, frame_completed);
		@(posedge Clk);
		#1;
		Ready = 1'b0;
		wait_done(hold, toggle);
		Ready = 1'b0;
		check_frame(exp_mag[idx]);
	endtask

	task automatic run_back_to_back(input int a, input int b, input mag_frame_t hold);
		s = stim[a];
		Ready = 1'b1;
		@(posedge Clk);
		#1;
		s = stim[b]; // picked up at the next E0.
		wait_done(hold, 1'b0);
		check_frame(exp_mag[a]);
		@(posedge Clk);
		#1;
		check_bit("frame_completed", 1'b0, frame_completed); // one-cycle done pulse.
		Ready = 1'b0;
		wait_done(exp_mag[a], 1'b0);
		check_frame(exp_mag[b]);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - err_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int err_before;
		mag_frame_t prev;
		void'($urandom(45126));
		Reset = 1'b1;
		Ready = 1'b0;
		s = '0;
		build_table();
		repeat (2) @(posedge Clk);
		#1;
		Reset = 1'b0;

		err_before = errors;
		check_bit("frame_completed", 1'b1, frame_completed);
		check_frame('0);
		end_test("reset", err_before);

		prev = '0;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			err_before = errors;
			apply_frame(f, 1'b0, prev);
			end_test($sformatf("frame %0d", f), err_before);
			prev = exp_mag[f];
		end

		err_before = errors;
		apply_frame(3, 1'b1, prev); // Ready and s toggled while busy.
		end_test("ready toggled while busy", err_before);
		prev = exp_mag[3];

		err_before = errors;
		run_back_to_back(5, 6, prev);
		end_test("ready held over two frames", err_before);

		$display("tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fft_core.f
+incdir+.
fft_pkg.sv
fft_butterfly.sv
fft_stage.sv
fft_sequencer.sv
fft_frame_buffer.sv
fft_magnitude_out.sv
fft_core.sv
tb_fft_core.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f fft_core.f --top-module tb_fft_core -o tb_fft_core

./obj_dir/tb_fft_core > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run reported errors, see sim.log"
	exit 1
fi
exit 0
